//--- src/vigil_pkg.sv
// Shared widths, memory map and I/O port constants, ROM offsets and arbiter states
package vigil_pkg;

    // Bus and data widths
    typedef logic [15:0] cpu_addr_t;
    typedef logic [17:0] rom_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  bank_t;

    // Video positions
    typedef logic [8:0]  scr1_pos_t;
    typedef logic [10:0] scr2_pos_t;
    typedef logic [7:0]  line_t;

    // ROM port arbitration
    typedef enum logic [1:0] {
        arb_idle,
        arb_cpu,
        arb_fetch
    } arb_state_t;

    // External ROM layout
    localparam rom_addr_t bank_rom_offset = 18'h08000;
    localparam rom_addr_t gfx_rom_base    = 18'h30000;

    // Work RAM is 4 KB
    localparam int ram_aw = 12;

    // I/O read ports
    localparam byte_t io_in0  = 8'h00;
    localparam byte_t io_in1  = 8'h01;
    localparam byte_t io_in2  = 8'h02;
    localparam byte_t io_dip1 = 8'h03;
    localparam byte_t io_dip2 = 8'h04;

    // I/O write ports, low group decoded with address bit 7 clear
    localparam byte_t io_latch   = 8'h00;
    localparam byte_t io_out2    = 8'h01;
    localparam byte_t io_bank    = 8'h04;
    localparam byte_t io_scr1_lo = 8'h80;
    localparam byte_t io_scr1_hi = 8'h81;
    localparam byte_t io_scr2_lo = 8'h82;
    localparam byte_t io_scr2_hi = 8'h83;
    localparam byte_t io_scr2col = 8'h84;

endpackage

//--- src/vigil_cpu_decode.sv
// CPU bus slave: memory and I/O decode, control registers, input ports and ROM banking
`timescale 1ns/1ns

module vigil_cpu_decode (
    input  logic                  clk,
    input  logic                  rst,
    // CPU bus
    input  logic                  cpu_valid,
    output logic                  cpu_ready,
    input  vigil_pkg::cpu_addr_t  cpu_addr,
    input  logic                  cpu_io,
    input  logic                  cpu_we,
    input  vigil_pkg::byte_t      cpu_wdata,
    output vigil_pkg::byte_t      cpu_rdata,
    // Interrupt
    input  logic                  vblank,
    input  logic                  dip_pause,
    output logic                  irq_n,
    // Cabinet
    input  logic [5:0]            joystick1,
    input  logic [5:0]            joystick2,
    input  logic [1:0]            cab_1p,
    input  logic [1:0]            coin,
    input  logic                  service,
    input  vigil_pkg::byte_t      dipsw_a,
    input  vigil_pkg::byte_t      dipsw_b,
    // Work RAM
    output logic                  ram_req,
    output logic                  ram_we,
    output logic [vigil_pkg::ram_aw-1:0] ram_addr,
    output vigil_pkg::byte_t      ram_wdata,
    input  vigil_pkg::byte_t      ram_rdata,
    // ROM through the arbiter
    output logic                  cpu_rom_valid,
    input  logic                  cpu_rom_ready,
    output vigil_pkg::rom_addr_t  cpu_rom_addr,
    input  vigil_pkg::byte_t      rom_rdata,
    // Video and sound control
    output logic                  flip,
    output logic                  latch_wr,
    output vigil_pkg::byte_t      sound_data,
    output vigil_pkg::scr1_pos_t  scr1pos,
    output vigil_pkg::scr2_pos_t  scr2pos,
    output logic [2:0]            scr2col,
    output logic                  scr2enb,
    output logic                  scr_cs,
    output logic                  obj_cs,
    output logic                  pal_cs
);

    logic               busy, start, ram_ack, io_wr, flip_r;
    logic               mem_rom, mem_ram, mem_scr, mem_pal, mem_obj, rom_rd;
    vigil_pkg::bank_t   bank;
    vigil_pkg::byte_t   rd_mux, rdata_q;

    // Write ports see address bit 7, read ports only the low three bits
    function automatic logic wr_hit(input vigil_pkg::byte_t port, input vigil_pkg::byte_t sel);
        return port[7] == sel[7] && port[2:0] == sel[2:0];
    endfunction

    function automatic logic rd_hit(input vigil_pkg::byte_t port, input vigil_pkg::byte_t sel);
        return port[2:0] == sel[2:0];
    endfunction

    assign start   = cpu_valid && !busy;
    assign mem_rom = !cpu_io && (!cpu_addr[15] || cpu_addr[15:14] == 2'b10);
    assign mem_ram = !cpu_io && cpu_addr[15:12] == 4'he;
    assign mem_scr = !cpu_io && cpu_addr[15:12] == 4'hd;
    assign mem_pal = !cpu_io && cpu_addr[15:11] == 5'b11001;
    // Object RAM is write only
    assign mem_obj = !cpu_io && cpu_addr[15:11] == 5'b11000 && cpu_we;
    assign rom_rd  = mem_rom && !cpu_we;
    assign io_wr   = cpu_valid && cpu_ready && cpu_io && cpu_we;
    assign irq_n   = !(vblank && dip_pause);

    // Banked window adds the 16 KB bank on top of the offset
    assign cpu_rom_addr = cpu_addr[15] ?
        {1'b0, bank, cpu_addr[13:0]} + vigil_pkg::bank_rom_offset :
        {3'd0, cpu_addr[14:0]};

    assign ram_we    = cpu_we;
    assign ram_addr  = cpu_addr[vigil_pkg::ram_aw-1:0];
    assign ram_wdata = cpu_wdata;
    assign cpu_rdata = ram_ack ? ram_rdata : rdata_q;

    always_comb begin
        rd_mux = 8'hff;
        if (cpu_io) begin
            if (rd_hit(cpu_addr[7:0], vigil_pkg::io_in0))
                rd_mux = {4'hf, coin[0], service, cab_1p};
            else if (rd_hit(cpu_addr[7:0], vigil_pkg::io_in1))
                rd_mux = {joystick1[5], 1'b1, joystick1[4], 1'b1, joystick1[3:0]};
            else if (rd_hit(cpu_addr[7:0], vigil_pkg::io_in2))
                rd_mux = {joystick2[5], 1'b1, joystick2[4], 1'b1, joystick2[3:0]};
            else if (rd_hit(cpu_addr[7:0], vigil_pkg::io_dip1))
                rd_mux = dipsw_a;
            else if (rd_hit(cpu_addr[7:0], vigil_pkg::io_dip2))
                rd_mux = dipsw_b;
        end
    end

    // Access sequencing
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy          <= 1'b0;
            cpu_ready     <= 1'b0;
            ram_req       <= 1'b0;
            ram_ack       <= 1'b0;
            cpu_rom_valid <= 1'b0;
            scr_cs        <= 1'b0;
            obj_cs        <= 1'b0;
            pal_cs        <= 1'b0;
        end else begin
            ram_req   <= start && mem_ram;
            ram_ack   <= ram_req;
            scr_cs    <= start && mem_scr;
            obj_cs    <= start && mem_obj;
            pal_cs    <= start && mem_pal;
            cpu_ready <= (start && !rom_rd && !mem_ram) || ram_req ||
                         (cpu_rom_valid && cpu_rom_ready);
            if (start)
                busy <= 1'b1;
            else if (cpu_ready)
                busy <= 1'b0;
            if (start && rom_rd)
                cpu_rom_valid <= 1'b1;
            else if (cpu_rom_ready)
                cpu_rom_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            rdata_q <= rd_mux;
        else if (cpu_rom_valid && cpu_rom_ready)
            rdata_q <= rom_rdata;
    end

    // Control registers, loaded on the accepted I/O write
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank       <= '0;
            scr1pos    <= '0;
            scr2pos    <= '0;
            scr2col    <= '0;
            scr2enb    <= 1'b0;
            flip_r     <= 1'b0;
            flip       <= 1'b0;
            latch_wr   <= 1'b0;
            sound_data <= '0;
        end else begin
            flip     <= flip_r ^ dipsw_b[0];
            latch_wr <= io_wr && wr_hit(cpu_addr[7:0], vigil_pkg::io_latch);
            if (io_wr && wr_hit(cpu_addr[7:0], vigil_pkg::io_latch))
                sound_data <= cpu_wdata;
            if (io_wr && wr_hit(cpu_addr[7:0], vigil_pkg::io_out2))
                flip_r <= cpu_wdata[0];
            if (io_wr && wr_hit(cpu_addr[7:0], vigil_pkg::io_bank))
                bank <= cpu_wdata[2:0];
            if (io_wr && wr_hit(cpu_addr[7:0], vigil_pkg::io_scr1_lo))
                scr1pos[7:0] <= cpu_wdata;
            if (io_wr && wr_hit(cpu_addr[7:0], vigil_pkg::io_scr1_hi))
                scr1pos[8] <= cpu_wdata[0];
            if (io_wr && wr_hit(cpu_addr[7:0], vigil_pkg::io_scr2_lo))
                scr2pos[7:0] <= cpu_wdata;
            if (io_wr && wr_hit(cpu_addr[7:0], vigil_pkg::io_scr2_hi))
                scr2pos[10:8] <= cpu_wdata[2:0];
            if (io_wr && wr_hit(cpu_addr[7:0], vigil_pkg::io_scr2col)) begin
                // Bit 6 enables layer 2
                scr2enb <= cpu_wdata[6];
                scr2col <= {cpu_wdata[3:2], cpu_wdata[0]};
            end
        end
    end

endmodule

//--- src/vigil_work_ram.sv
// Byte-wide work RAM with a registered read port
`timescale 1ns/1ns

module vigil_work_ram (
    input  logic                         clk,
    input  logic                         ram_req,
    input  logic                         ram_we,
    input  logic [vigil_pkg::ram_aw-1:0] ram_addr,
    input  vigil_pkg::byte_t             ram_wdata,
    output vigil_pkg::byte_t             ram_rdata
);

    vigil_pkg::byte_t mem [0:(1 << vigil_pkg::ram_aw)-1];

    // Data shows up the cycle after the request
    always_ff @(posedge clk) begin
        if (ram_req) begin
            if (ram_we)
                mem[ram_addr] <= ram_wdata;
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

//--- src/vigil_scroll_fetch.sv
// Per-line graphics byte fetcher for scroll layer 1
`timescale 1ns/1ns

module vigil_scroll_fetch (
    input  logic                 clk,
    input  logic                 rst,
    // Video timing and scroll position
    input  logic                 line_start,
    input  vigil_pkg::line_t     line,
    input  vigil_pkg::scr1_pos_t scr1pos,
    // ROM request
    output logic                 fetch_valid,
    input  logic                 fetch_ready,
    output vigil_pkg::rom_addr_t fetch_addr,
    input  vigil_pkg::byte_t     rom_rdata,
    // Fetched byte
    output vigil_pkg::byte_t     tile_data,
    output logic                 tile_strobe
);

    // Line starts while a fetch is pending are dropped
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            fetch_valid <= 1'b0;
            tile_strobe <= 1'b0;
        end else begin
            tile_strobe <= fetch_valid && fetch_ready;
            if (fetch_valid) begin
                if (fetch_ready)
                    fetch_valid <= 1'b0;
            end else if (line_start) begin
                fetch_valid <= 1'b1;
            end
        end
    end

    // 512 bytes per line, indexed by the layer 1 position
    always_ff @(posedge clk) begin
        if (!fetch_valid && line_start)
            fetch_addr <= vigil_pkg::gfx_rom_base + {1'b0, line, scr1pos};
        if (fetch_valid && fetch_ready)
            tile_data <= rom_rdata;
    end

endmodule

//--- src/vigil_rom_arbiter.sv
// Two-master arbiter for the external ROM port, CPU first with alternation on contention
`timescale 1ns/1ns

module vigil_rom_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    // CPU program fetches
    input  logic                 cpu_rom_valid,
    output logic                 cpu_rom_ready,
    input  vigil_pkg::rom_addr_t cpu_rom_addr,
    // Scroll tile fetches
    input  logic                 fetch_valid,
    output logic                 fetch_ready,
    input  vigil_pkg::rom_addr_t fetch_addr,
    // External ROM
    output logic                 rom_valid,
    input  logic                 rom_ready,
    output vigil_pkg::rom_addr_t rom_addr
);

    vigil_pkg::arb_state_t state;
    logic                  last_cpu;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= vigil_pkg::arb_idle;
            last_cpu <= 1'b0;
        end else begin
            case (state)
                vigil_pkg::arb_idle: begin
                    // Fetcher gets its turn right after a CPU grant
                    if (cpu_rom_valid && (!fetch_valid || !last_cpu)) begin
                        state    <= vigil_pkg::arb_cpu;
                        last_cpu <= 1'b1;
                    end else if (fetch_valid) begin
                        state    <= vigil_pkg::arb_fetch;
                        last_cpu <= 1'b0;
                    end
                end
                vigil_pkg::arb_cpu, vigil_pkg::arb_fetch: begin
                    if (rom_ready)
                        state <= vigil_pkg::arb_idle;
                end
                default: state <= vigil_pkg::arb_idle;
            endcase
        end
    end

    // Granted master owns the port until the ROM answers
    always_comb begin
        rom_valid     = state != vigil_pkg::arb_idle;
        rom_addr      = state == vigil_pkg::arb_fetch ? fetch_addr : cpu_rom_addr;
        cpu_rom_ready = state == vigil_pkg::arb_cpu && rom_ready;
        fetch_ready   = state == vigil_pkg::arb_fetch && rom_ready;
    end

endmodule

//--- src/vigil_main.sv
// Main CPU bus block top: decoder, work RAM, scroll fetcher and ROM arbiter
`timescale 1ns/1ns

module vigil_main (
    input  logic                  clk,
    input  logic                  rst,
    // CPU request port
    input  logic                  cpu_valid,
    output logic                  cpu_ready,
    input  vigil_pkg::cpu_addr_t  cpu_addr,
    input  logic                  cpu_io,
    input  logic                  cpu_we,
    input  vigil_pkg::byte_t      cpu_wdata,
    output vigil_pkg::byte_t      cpu_rdata,
    output logic                  irq_n,
    // Video timing
    input  logic                  vblank,
    input  logic                  dip_pause,
    input  logic                  line_start,
    input  vigil_pkg::line_t      line,
    // Cabinet and DIP switches
    input  logic [5:0]            joystick1,
    input  logic [5:0]            joystick2,
    input  logic [1:0]            cab_1p,
    input  logic [1:0]            coin,
    input  logic                  service,
    input  vigil_pkg::byte_t      dipsw_a,
    input  vigil_pkg::byte_t      dipsw_b,
    // Video and sound control
    output logic                  flip,
    output logic                  latch_wr,
    output vigil_pkg::byte_t      sound_data,
    output vigil_pkg::scr1_pos_t  scr1pos,
    output vigil_pkg::scr2_pos_t  scr2pos,
    output logic [2:0]            scr2col,
    output logic                  scr2enb,
    output logic                  scr_cs,
    output logic                  obj_cs,
    output logic                  pal_cs,
    // Tile bytes for the scroll layer
    output vigil_pkg::byte_t      tile_data,
    output logic                  tile_strobe,
    // External ROM
    output logic                  rom_valid,
    input  logic                  rom_ready,
    output vigil_pkg::rom_addr_t  rom_addr,
    input  vigil_pkg::byte_t      rom_data
);

    logic                        ram_req;
    logic                        ram_we;
    logic [vigil_pkg::ram_aw-1:0] ram_addr;
    vigil_pkg::byte_t            ram_wdata;
    vigil_pkg::byte_t            ram_rdata;

    logic                        cpu_rom_valid;
    logic                        cpu_rom_ready;
    vigil_pkg::rom_addr_t        cpu_rom_addr;

    logic                        fetch_valid;
    logic                        fetch_ready;
    vigil_pkg::rom_addr_t        fetch_addr;

    vigil_cpu_decode u_decode (
        .clk, .rst,
        .cpu_valid, .cpu_ready, .cpu_addr, .cpu_io, .cpu_we, .cpu_wdata, .cpu_rdata,
        .vblank, .dip_pause, .irq_n,
        .joystick1, .joystick2, .cab_1p, .coin, .service, .dipsw_a, .dipsw_b,
        .ram_req, .ram_we, .ram_addr, .ram_wdata, .ram_rdata,
        .cpu_rom_valid, .cpu_rom_ready, .cpu_rom_addr,
        .rom_rdata  ( rom_data ),
        .flip, .latch_wr, .sound_data, .scr1pos, .scr2pos, .scr2col, .scr2enb,
        .scr_cs, .obj_cs, .pal_cs
    );

    vigil_work_ram u_ram (
        .clk, .ram_req, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
    );

    vigil_scroll_fetch u_fetch (
        .clk, .rst, .line_start, .line, .scr1pos,
        .fetch_valid, .fetch_ready, .fetch_addr,
        .rom_rdata  ( rom_data ),
        .tile_data, .tile_strobe
    );

    vigil_rom_arbiter u_arbiter (
        .clk, .rst,
        .cpu_rom_valid, .cpu_rom_ready, .cpu_rom_addr,
        .fetch_valid, .fetch_ready, .fetch_addr,
        .rom_valid, .rom_ready, .rom_addr
    );

endmodule

//--- sim/vigil_rom_model.sv
// External ROM model: address-derived data with a random response delay
`timescale 1ns/1ns

module vigil_rom_model (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rom_valid,
    output logic                 rom_ready,
    input  vigil_pkg::rom_addr_t rom_addr,
    output vigil_pkg::byte_t     rom_data
);

    integer     seed = 32'h2c50_02c9;
    logic       busy;
    logic [1:0] wait_cnt;

    // Answers on the falling edge, one to four cycles after the request shows up
    always @(negedge clk or posedge rst) begin
        if (rst) begin
            rom_ready <= 1'b0;
            rom_data  <= '0;
            busy      <= 1'b0;
            wait_cnt  <= '0;
        end else if (rom_ready) begin
            rom_ready <= 1'b0;
        end else if (rom_valid) begin
            if (!busy) begin
                busy     <= 1'b1;
                wait_cnt <= $random(seed);
            end else if (wait_cnt == 2'd0) begin
                // Low address byte mixed with the upper address bits
                rom_data  <= rom_addr[7:0] ^ rom_addr[17:10];
                rom_ready <= 1'b1;
                busy      <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

//--- sim/vigil_main_tb.sv
// Testbench with CPU bus driver, reference models, tile and chip select checks and watchdog
`timescale 1ns/1ns

module vigil_main_tb;

    localparam int num_tests = 7;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 cpu_valid, cpu_ready, cpu_io, cpu_we;
    logic [15:0]          cpu_addr;
    logic [7:0]           cpu_wdata, cpu_rdata;
    logic                 irq_n, vblank, dip_pause, line_start;
    logic [7:0]           line;
    logic [5:0]           joystick1, joystick2;
    logic [1:0]           cab_1p, coin;
    logic                 service;
    logic [7:0]           dipsw_a, dipsw_b;
    logic                 flip, latch_wr, scr2enb, scr_cs, obj_cs, pal_cs;
    logic [7:0]           sound_data, tile_data, rom_data;
    logic [8:0]           scr1pos;
    logic [10:0]          scr2pos;
    logic [2:0]           scr2col;
    logic                 tile_strobe, rom_valid, rom_ready;
    vigil_pkg::rom_addr_t rom_addr;

    integer               seed = 32'h2c50_02c9;
    int                   errors = 0;
    int                   errors_at_start, tests_run, tests_failed;
    int                   latch_count = 0;
    int                   scr_count = 0;
    int                   obj_count = 0;
    int                   pal_count = 0;
    int                   strobe_count = 0;
    string                cur_test;
    logic [2:0]           cur_bank;
    logic [8:0]           exp_scr1;
    vigil_pkg::rom_addr_t tile_q[$];
    logic [7:0]           ram_shadow [0:4095];
    logic [11:0]          ram_wa [0:31];
    logic [7:0]           line_list [0:9];
    logic [15:0]          cpu_list [0:15];

    vigil_main dut0 (
        .clk, .rst, .cpu_valid, .cpu_ready, .cpu_addr, .cpu_io, .cpu_we, .cpu_wdata,
        .cpu_rdata, .irq_n, .vblank, .dip_pause, .line_start, .line,
        .joystick1, .joystick2, .cab_1p, .coin, .service, .dipsw_a, .dipsw_b,
        .flip, .latch_wr, .sound_data, .scr1pos, .scr2pos, .scr2col, .scr2enb,
        .scr_cs, .obj_cs, .pal_cs, .tile_data, .tile_strobe,
        .rom_valid, .rom_ready, .rom_addr, .rom_data
    );

    vigil_rom_model rom0 (
        .clk, .rst, .rom_valid, .rom_ready, .rom_addr, .rom_data
    );

    always #5 clk = ~clk;

    // CPU address to external ROM address through the bank window at 8000
    function automatic vigil_pkg::rom_addr_t rom_ref_addr(input logic [2:0] bank,
                                                          input logic [15:0] addr);
        int a;
        if (addr < 16'h8000)
            a = addr;
        else
            a = vigil_pkg::bank_rom_offset + bank * 16'h4000 + (addr - 16'h8000);
        return a[17:0];
    endfunction

    function automatic logic [7:0] rom_byte(input vigil_pkg::rom_addr_t a);
        return a[7:0] ^ a[17:10];
    endfunction

    function automatic vigil_pkg::rom_addr_t tile_ref_addr(input logic [7:0] ln,
                                                           input logic [8:0] pos);
        int sum;
        sum = vigil_pkg::gfx_rom_base + ln * 512 + pos;
        return sum[17:0];
    endfunction

    // Expected input port bytes from the current cabinet inputs
    function automatic logic [7:0] port_ref(input int port);
        case (port)
            0: return {4'b1111, coin[0], service, cab_1p};
            1: return {joystick1[5], 1'b1, joystick1[4], 1'b1, joystick1[3:0]};
            2: return {joystick2[5], 1'b1, joystick2[4], 1'b1, joystick2[3:0]};
            3: return dipsw_a;
            4: return dipsw_b;
            default: return 8'hff;
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("mismatch %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    // One bus beat with the request held through the ready cycle
    task automatic cpu_access(input logic io, input logic we, input logic [15:0] addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        @(negedge clk);
        cpu_valid = 1'b1;
        cpu_io    = io;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        do @(negedge clk); while (!cpu_ready);
        rdata = cpu_rdata;
        @(negedge clk);
        cpu_valid = 1'b0;
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        logic [7:0] unused_rd;
        cpu_access(1'b1, 1'b1, {8'h00, port}, data, unused_rd);
    endtask

    // Pulse counts for the sound latch strobe and the chip selects
    always @(negedge clk) begin
        if (latch_wr)
            latch_count++;
        if (scr_cs)
            scr_count++;
        if (obj_cs)
            obj_count++;
        if (pal_cs)
            pal_count++;
    end

    // Each tile byte against the oldest pending line start
    always @(negedge clk) begin : tile_check
        vigil_pkg::rom_addr_t a;
        if (tile_strobe) begin
            strobe_count++;
            if (tile_q.size() == 0) begin
                $display("error in %s: tile strobe with no line start pending", cur_test);
                errors++;
            end else begin
                a = tile_q.pop_front();
                if (tile_data !== rom_byte(a))
                    report_mismatch("tile byte", rom_byte(a), tile_data);
            end
        end
    end

    initial begin : watchdog
        repeat (num_tests * 200 + 1000) @(posedge clk);
        $display("watchdog: run still busy after %0d cycles", num_tests * 200 + 1000);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        int         i, b, p, li, ci, strobes_before, issued, wait_cycles;
        int         obj_before, pal_before, scr_before;
        logic [15:0] addr;
        logic [7:0]  rd, rd6, exp, lo, hi, col;
        tests_run    = 0;
        tests_failed = 0;
        rst = 1'b1;
        cpu_valid = 1'b0;
        cpu_addr  = '0;
        cpu_io    = 1'b0;
        cpu_we    = 1'b0;
        cpu_wdata = '0;
        vblank    = 1'b0;
        dip_pause = 1'b0;
        line_start = 1'b0;
        line      = '0;
        joystick1 = '0;
        joystick2 = '0;
        cab_1p    = '0;
        coin      = '0;
        service   = 1'b0;
        dipsw_a   = '0;
        dipsw_b   = '0;
        cur_bank  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("rom_banking");
        repeat (12) begin
            addr = $random(seed) & 16'h7fff;
            cpu_access(1'b0, 1'b0, addr, 8'h00, rd);
            exp = rom_byte(rom_ref_addr(cur_bank, addr));
            if (rd !== exp)
                report_mismatch("fixed rom read", exp, rd);
        end
        for (b = 0; b < 8; b++) begin
            io_write(vigil_pkg::io_bank, b[7:0]);
            cur_bank = b[2:0];
            repeat (3) begin
                addr = 16'h8000 | ($random(seed) & 16'h3fff);
                cpu_access(1'b0, 1'b0, addr, 8'h00, rd);
                exp = rom_byte(rom_ref_addr(cur_bank, addr));
                if (rd !== exp)
                    report_mismatch("banked rom read", exp, rd);
            end
        end
        end_test();

        begin_test("work_ram");
        for (i = 0; i < 32; i++) begin
            ram_wa[i] = $random(seed);
            rd = $random(seed);
            ram_shadow[ram_wa[i]] = rd;
            cpu_access(1'b0, 1'b1, 16'he000 | ram_wa[i], rd, rd6);
        end
        for (i = 0; i < 32; i++) begin
            cpu_access(1'b0, 1'b0, 16'he000 | ram_wa[i], 8'h00, rd);
            if (rd !== ram_shadow[ram_wa[i]])
                report_mismatch("ram read", ram_shadow[ram_wa[i]], rd);
        end
        end_test();

        begin_test("scroll_regs");
        repeat (4) begin
            lo = $random(seed);
            hi = $random(seed);
            io_write(vigil_pkg::io_scr1_lo, lo);
            io_write(vigil_pkg::io_scr1_hi, hi);
            exp_scr1 = {hi[0], lo};
            if (scr1pos !== exp_scr1)
                report_mismatch("scr1pos", exp_scr1, scr1pos);
            io_write(vigil_pkg::io_scr2_lo, hi);
            io_write(vigil_pkg::io_scr2_hi, lo);
            if (scr2pos !== {lo[2:0], hi})
                report_mismatch("scr2pos", {lo[2:0], hi}, scr2pos);
            col = $random(seed);
            io_write(vigil_pkg::io_scr2col, col);
            if (scr2col !== {col[3], col[2], col[0]})
                report_mismatch("scr2col", {col[3], col[2], col[0]}, scr2col);
            if (scr2enb !== col[6])
                report_mismatch("scr2enb", col[6], scr2enb);
        end
        end_test();

        begin_test("input_ports");
        repeat (4) begin
            @(negedge clk);
            joystick1 = $random(seed);
            joystick2 = $random(seed);
            coin      = $random(seed);
            cab_1p    = $random(seed);
            service   = $random(seed);
            dipsw_a   = $random(seed);
            dipsw_b   = $random(seed);
            for (p = 0; p < 5; p++) begin
                cpu_access(1'b1, 1'b0, p[15:0], 8'h00, rd);
                if (rd !== port_ref(p))
                    report_mismatch($sformatf("port %0d", p), port_ref(p), rd);
            end
        end
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            dipsw_b[0] = i[1];
            io_write(vigil_pkg::io_out2, {7'h00, i[0]});
            @(negedge clk);
            if (flip !== (i[0] ^ i[1]))
                report_mismatch("flip", i[0] ^ i[1], flip);
        end
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            vblank    = i[0];
            dip_pause = i[1];
            #1;
            if (irq_n !== !(i[0] && i[1]))
                report_mismatch("irq_n", !(i[0] && i[1]), irq_n);
        end
        @(negedge clk);
        vblank    = 1'b0;
        dip_pause = 1'b0;
        end_test();

        begin_test("sound_latch");
        b = latch_count;
        exp = $random(seed);
        io_write(vigil_pkg::io_latch, exp);
        repeat (2) @(negedge clk);
        if (latch_count !== b + 1)
            report_mismatch("latch_wr pulses", b + 1, latch_count);
        if (sound_data !== exp)
            report_mismatch("sound_data", exp, sound_data);
        end_test();

        // Object RAM selects on writes only, palette and scroll RAM on both
        begin_test("chip_selects");
        obj_before = obj_count;
        pal_before = pal_count;
        scr_before = scr_count;
        cpu_access(1'b0, 1'b1, 16'hc000 | ($random(seed) & 16'h07ff), 8'h5a, rd6);
        cpu_access(1'b0, 1'b0, 16'hc000 | ($random(seed) & 16'h07ff), 8'h00, rd6);
        cpu_access(1'b0, 1'b0, 16'hc800 | ($random(seed) & 16'h07ff), 8'h00, rd6);
        cpu_access(1'b0, 1'b1, 16'hc800 | ($random(seed) & 16'h07ff), 8'h33, rd6);
        cpu_access(1'b0, 1'b0, 16'hd000, 8'h00, rd6);
        repeat (2) @(negedge clk);
        if (obj_count !== obj_before + 1)
            report_mismatch("obj_cs pulses", obj_before + 1, obj_count);
        if (pal_count !== pal_before + 2)
            report_mismatch("pal_cs pulses", pal_before + 2, pal_count);
        if (scr_count !== scr_before + 1)
            report_mismatch("scr_cs pulses", scr_before + 1, scr_count);
        end_test();

        begin_test("rom_arbitration");
        lo = $random(seed);
        hi = $random(seed);
        io_write(vigil_pkg::io_scr1_lo, lo);
        io_write(vigil_pkg::io_scr1_hi, hi);
        exp_scr1 = {hi[0], lo};
        for (i = 0; i < 10; i++)
            line_list[i] = $random(seed);
        for (i = 0; i < 16; i++) begin
            cpu_list[i] = $random(seed);
            if (cpu_list[i][15:14] == 2'b11)
                cpu_list[i][14] = 1'b0;
        end
        strobes_before = strobe_count;
        issued = 0;
        fork
            begin
                for (li = 0; li < 10; li++) begin
                    @(negedge clk);
                    line = line_list[li];
                    line_start = 1'b1;
                    tile_q.push_back(tile_ref_addr(line_list[li], exp_scr1));
                    issued++;
                    @(negedge clk);
                    line_start = 1'b0;
                    wait_cycles = 0;
                    while (!tile_strobe && wait_cycles < 100) begin
                        @(negedge clk);
                        wait_cycles++;
                    end
                end
            end
            begin
                for (ci = 0; ci < 16; ci++) begin
                    cpu_access(1'b0, 1'b0, cpu_list[ci], 8'h00, rd6);
                    if (rd6 !== rom_byte(rom_ref_addr(cur_bank, cpu_list[ci])))
                        report_mismatch("cpu rom read under load",
                                        rom_byte(rom_ref_addr(cur_bank, cpu_list[ci])), rd6);
                end
            end
        join
        repeat (2) @(negedge clk);
        if (strobe_count - strobes_before !== issued)
            report_mismatch("tile strobe count", issued, strobe_count - strobes_before);
        if (tile_q.size() != 0) begin
            $display("error in %s: %0d tile fetches never completed", cur_test, tile_q.size());
            errors++;
        end
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- vigil_main.f
src/vigil_pkg.sv
src/vigil_cpu_decode.sv
src/vigil_work_ram.sv
src/vigil_scroll_fetch.sv
src/vigil_rom_arbiter.sv
src/vigil_main.sv
sim/vigil_rom_model.sv
sim/vigil_main_tb.sv

//--- Bender.yml
package:
  name: vigil_main

sources:
  - src/vigil_pkg.sv
  - src/vigil_cpu_decode.sv
  - src/vigil_work_ram.sv
  - src/vigil_scroll_fetch.sv
  - src/vigil_rom_arbiter.sv
  - src/vigil_main.sv
  - target: simulation
    files:
      - sim/vigil_rom_model.sv
      - sim/vigil_main_tb.sv
